// File: common/nocPkg.sv
`default_nettype none

package nocPkg;

	// router geometry
	localparam int NUM_PORTS = 5;
	localparam int COORD_W = 4;
	localparam int FLIT_W = 2 * COORD_W;

	// input FIFO depth, also the starting credit count of each output
	localparam int BUF_DEPTH = 4;
	localparam int PTR_W = $clog2(BUF_DEPTH);
	localparam int CREDIT_W = 3;

	// port index, doubles as the crossbar select code
	typedef enum logic [2:0] {
		North = 3'b000,
		South = 3'b001,
		East = 3'b010,
		West = 3'b011,
		Local = 3'b100
	} portE;

	// destination x in the upper nibble, y in the lower
	typedef struct packed {
		logic [COORD_W-1:0] destX;
		logic [COORD_W-1:0] destY;
	} flitT;

endpackage

`default_nettype wire

// File: common/outPortIf.sv
`timescale 1ns/1ps
`default_nettype none

// control path between route logic and one output stage
interface outPortIf;

	nocPkg::portE select;
	logic enable;
	logic full;
	// one-hot, North in the MSB
	logic [nocPkg::NUM_PORTS-1:0] turn;

	modport route (
		output select,
		output enable,
		input full,
		input turn
	);

	modport stage (
		input select,
		input enable,
		output full,
		output turn
	);

endinterface

`default_nettype wire

// File: router/inputBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module inputBuffer (
	input wire logic clk,
	input wire logic reset_i,
	input wire nocPkg::flitT inData_i,
	input wire logic inValid_i,
	input wire logic remove_i,
	output nocPkg::flitT headFlit_o,
	output logic headValid_o,
	output logic creditOut_o
);

	nocPkg::flitT mem [nocPkg::BUF_DEPTH];
	logic [nocPkg::PTR_W-1:0] rdPtr;
	logic [nocPkg::PTR_W-1:0] wrPtr;
	logic [nocPkg::CREDIT_W-1:0] count;
	logic doPop;

	// upstream credits keep the FIFO from overflowing
	assign headValid_o = (count != '0);
	assign headFlit_o = mem[rdPtr];
	assign doPop = remove_i && headValid_o;

	// storage
	always_ff @(posedge clk) begin
		if (inValid_i) begin
			mem[wrPtr] <= inData_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			creditOut_o <= 1'b0;
		end else begin
			if (inValid_i) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({inValid_i, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back upstream per popped flit
			creditOut_o <= doPop;
		end
	end

endmodule

`default_nettype wire

// File: router/routeLogic.sv
`timescale 1ns/1ps
`default_nettype none

module routeLogic #(
	parameter int XCOORD = 0,
	parameter int YCOORD = 0
) (
	input wire nocPkg::flitT headFlit_i [nocPkg::NUM_PORTS],
	input wire logic [nocPkg::NUM_PORTS-1:0] headValid_i,
	output logic [nocPkg::NUM_PORTS-1:0] remove_o,
	outPortIf.route outPort [nocPkg::NUM_PORTS]
);

	logic [nocPkg::NUM_PORTS-1:0] outFull;
	logic [nocPkg::NUM_PORTS-1:0] outTurn [nocPkg::NUM_PORTS];
	logic [nocPkg::NUM_PORTS-1:0] outEnable;
	nocPkg::portE outSelect [nocPkg::NUM_PORTS];

	// y first, then x; larger y is South, larger x is East
	function automatic nocPkg::portE yFirstPort(input nocPkg::flitT f);
		nocPkg::portE dir;
		if (int'(f.destY) > YCOORD) begin
			dir = nocPkg::South;
		end else if (int'(f.destY) < YCOORD) begin
			dir = nocPkg::North;
		end else if (int'(f.destX) > XCOORD) begin
			dir = nocPkg::East;
		end else if (int'(f.destX) < XCOORD) begin
			dir = nocPkg::West;
		end else begin
			dir = nocPkg::Local;
		end
		return dir;
	endfunction

	// arrivals that break Y-first ordering, or turn back, are illegal
	function automatic logic isLegal(input nocPkg::portE from, input nocPkg::portE to);
		logic ok;
		case (from)
			nocPkg::North: ok = (to != nocPkg::North);
			nocPkg::South: ok = (to != nocPkg::South);
			// x-dimension traffic must already have matched y
			nocPkg::East: ok = (to == nocPkg::West) || (to == nocPkg::Local);
			nocPkg::West: ok = (to == nocPkg::East) || (to == nocPkg::Local);
			default: ok = (to != nocPkg::Local);
		endcase
		return ok;
	endfunction

	// per-output control signals gathered into vectors
	for (genvar o = 0; o < nocPkg::NUM_PORTS; o++) begin : genOut
		assign outFull[o] = outPort[o].full;
		assign outTurn[o] = outPort[o].turn;
		assign outPort[o].enable = outEnable[o];
		assign outPort[o].select = outSelect[o];
	end

	always_comb begin : routeComb
		nocPkg::portE want;
		nocPkg::portE from;
		outEnable = '0;
		remove_o = '0;
		want = nocPkg::North;
		from = nocPkg::North;
		for (int o = 0; o < nocPkg::NUM_PORTS; o++) begin
			outSelect[o] = nocPkg::North;
		end
		for (int i = 0; i < nocPkg::NUM_PORTS; i++) begin
			from = nocPkg::portE'(i);
			want = yFirstPort(headFlit_i[i]);
			if (headValid_i[i]) begin
				if (!isLegal(from, want)) begin
					// dropped flits still return their credit
					remove_o[i] = 1'b1;
				end else if (!outFull[want] && outTurn[want][nocPkg::NUM_PORTS-1-i]) begin
					// one-hot turn means at most one grant per output
					remove_o[i] = 1'b1;
					outEnable[want] = 1'b1;
					outSelect[want] = from;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: router/outputStage.sv
`timescale 1ns/1ps
`default_nettype none

module outputStage (
	input wire logic clk,
	input wire logic reset_i,
	input wire nocPkg::flitT inFlits_i [nocPkg::NUM_PORTS],
	outPortIf.stage ctrl,
	input wire logic creditIn_i,
	output nocPkg::flitT outData_o,
	output logic outValid_o
);

	logic [nocPkg::CREDIT_W-1:0] credits;
	logic [nocPkg::NUM_PORTS-1:0] turnQ;
	nocPkg::flitT muxFlit;

	assign ctrl.full = (credits == '0);
	assign ctrl.turn = turnQ;

	// crossbar column
	always_comb begin
		case (ctrl.select)
			nocPkg::North: muxFlit = inFlits_i[nocPkg::North];
			nocPkg::South: muxFlit = inFlits_i[nocPkg::South];
			nocPkg::East: muxFlit = inFlits_i[nocPkg::East];
			nocPkg::West: muxFlit = inFlits_i[nocPkg::West];
			nocPkg::Local: muxFlit = inFlits_i[nocPkg::Local];
			default: muxFlit = inFlits_i[nocPkg::North];
		endcase
	end

	always_ff @(posedge clk) begin
		if (ctrl.enable) begin
			outData_o <= muxFlit;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			outValid_o <= 1'b0;
			turnQ <= {1'b1, {(nocPkg::NUM_PORTS-1){1'b0}}};
			credits <= nocPkg::CREDIT_W'(nocPkg::BUF_DEPTH);
		end else begin
			outValid_o <= ctrl.enable;
			// N -> S -> E -> W -> L -> N, every cycle
			turnQ <= {turnQ[0], turnQ[nocPkg::NUM_PORTS-1:1]};
			// send and credit return may coincide
			case ({ctrl.enable, creditIn_i})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/meshRouter.sv
`timescale 1ns/1ps
`default_nettype none

module meshRouter #(
	parameter int XCOORD = 0,
	parameter int YCOORD = 0
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic [nocPkg::NUM_PORTS-1:0][nocPkg::FLIT_W-1:0] inData_i,
	input wire logic [nocPkg::NUM_PORTS-1:0] inValid_i,
	output logic [nocPkg::NUM_PORTS-1:0] creditOut_o,
	output logic [nocPkg::NUM_PORTS-1:0][nocPkg::FLIT_W-1:0] outData_o,
	output logic [nocPkg::NUM_PORTS-1:0] outValid_o,
	input wire logic [nocPkg::NUM_PORTS-1:0] creditIn_i
);

	// all vectors indexed by port number, North = 0
	nocPkg::flitT headFlit [nocPkg::NUM_PORTS];
	logic [nocPkg::NUM_PORTS-1:0] headValid;
	logic [nocPkg::NUM_PORTS-1:0] remove;

	outPortIf outPort [nocPkg::NUM_PORTS] ();

	for (genvar p = 0; p < nocPkg::NUM_PORTS; p++) begin : genPort
		inputBuffer uBuf (
			.clk(clk),
			.reset_i(reset_i),
			.inData_i(nocPkg::flitT'(inData_i[p])),
			.inValid_i(inValid_i[p]),
			.remove_i(remove[p]),
			.headFlit_o(headFlit[p]),
			.headValid_o(headValid[p]),
			.creditOut_o(creditOut_o[p])
		);

		outputStage uOut (
			.clk(clk),
			.reset_i(reset_i),
			.inFlits_i(headFlit),
			.ctrl(outPort[p]),
			.creditIn_i(creditIn_i[p]),
			.outData_o(outData_o[p]),
			.outValid_o(outValid_o[p])
		);
	end

	routeLogic #(
		.XCOORD(XCOORD),
		.YCOORD(YCOORD)
	) uRoute (
		.headFlit_i(headFlit),
		.headValid_i(headValid),
		.remove_o(remove),
		.outPort(outPort)
	);

endmodule

`default_nettype wire

// File: dv/routerProps.sv
`timescale 1ns/1ps
`default_nettype none

module routerProps (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic enable_i,
	input wire logic full_i,
	input wire logic [nocPkg::NUM_PORTS-1:0] turn_i,
	input wire logic [nocPkg::CREDIT_W-1:0] credits_i,
	input wire logic outValid_i
);

	noSendWhenFull: assert property (@(posedge clk) disable iff (reset_i)
		!(enable_i && full_i)) else $error("output enabled while out of credits");

	turnOneHot: assert property (@(posedge clk) disable iff (reset_i)
		$onehot(turn_i)) else $error("turn vector is not one-hot");

	creditBound: assert property (@(posedge clk) disable iff (reset_i)
		credits_i <= nocPkg::CREDIT_W'(nocPkg::BUF_DEPTH))
		else $error("credit counter above buffer depth");

	// first cycle out of reset carries no flit
	quietAfterReset: assert property (@(posedge clk)
		$fell(reset_i) |=> !outValid_i) else $error("valid output right after reset");

endmodule

bind outputStage routerProps uProps (
	.clk(clk),
	.reset_i(reset_i),
	.enable_i(ctrl.enable),
	.full_i(ctrl.full),
	.turn_i(turnQ),
	.credits_i(credits),
	.outValid_i(outValid_o)
);

`default_nettype wire

// File: dv/tbMeshRouter.sv
`timescale 1ns/1ps
`default_nettype none

module tbMeshRouter;

	localparam int NP = nocPkg::NUM_PORTS;
	localparam int FLITS = 80;
	localparam int DROP = NP;
	localparam int HERE = 7;
	// 400 flits, 50 cycles each leaves room for the stall
	localparam int TIMEOUT = FLITS * NP * 50;
	localparam int STALL_START = 300;
	localparam int STALL_LEN = 40;

	logic clk;
	logic reset_i;
	logic [NP-1:0][nocPkg::FLIT_W-1:0] inData;
	logic [NP-1:0] inValid;
	logic [NP-1:0] creditOut;
	logic [NP-1:0][nocPkg::FLIT_W-1:0] outData;
	logic [NP-1:0] outValid;
	logic [NP-1:0] creditIn;

	logic [31:0] rngState;
	int cycle;
	int errors;
	int idleCycles;
	int sent [NP];
	int upCredits [NP];
	int downCredits [NP];
	int creditPulses [NP];
	int delivered [NP];
	int dropsExpected [NP];
	int srcOf [NP];
	// per input, the output (or DROP) of each flit in injection order
	int routeQ [NP][$];
	logic [7:0] pairQ [NP*NP][$];
	int returnQ [NP][$];

	meshRouter #(.XCOORD(HERE), .YCOORD(HERE)) UUT (
		.clk(clk),
		.reset_i(reset_i),
		.inData_i(inData),
		.inValid_i(inValid),
		.creditOut_o(creditOut),
		.outData_o(outData),
		.outValid_o(outValid),
		.creditIn_i(creditIn)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// 0 N, 1 S, 2 E, 3 W, 4 L
	function automatic int yFirstOut(input logic [7:0] flit);
		int x;
		int y;
		int dir;
		x = int'(flit[7:4]);
		y = int'(flit[3:0]);
		if (y != HERE) dir = (y > HERE) ? 0 + 1 : 0;
		else if (x != HERE) dir = (x > HERE) ? 2 : 3;
		else dir = 4;
		return dir;
	endfunction

	function automatic bit isDropped(input int from, input int dest);
		bit drop;
		case (from)
			0: drop = (dest == 0);
			1: drop = (dest == 1);
			// x traffic turning to y, or going back
			2, 3: drop = (dest < 2) || (dest == from);
			default: drop = (dest == 4);
		endcase
		return drop;
	endfunction

	task automatic checkOutputs();
		int r;
		logic [7:0] front;
		for (int p = 0; p < NP; p++) srcOf[p] = -1;
		for (int i = 0; i < NP; i++) begin
			if (creditOut[i]) begin
				creditPulses[i]++;
				upCredits[i]++;
				if (routeQ[i].size() == 0) begin
					errors++;
					$display("ERROR: input %0d returned a credit with no flit buffered", i);
				end else begin
					r = routeQ[i].pop_front();
					if (r != DROP) srcOf[r] = i;
				end
			end
		end
		for (int p = 0; p < NP; p++) begin
			if (outValid[p]) begin
				if (downCredits[p] == 0) begin
					errors++;
					$display("MISMATCH backpressure: output %0d expected valid 0, actual 1", p);
				end else begin
					downCredits[p]--;
				end
				returnQ[p].push_back(cycle + int'(nextRand() % 7));
				if (yFirstOut(outData[p]) != p) begin
					errors++;
					$display("MISMATCH routing: expected port %0d, actual port %0d",
						yFirstOut(outData[p]), p);
				end
				if (srcOf[p] < 0) begin
					errors++;
					$display("ERROR: output %0d sent flit %h that no input released",
						p, outData[p]);
				end else begin
					front = pairQ[srcOf[p]*NP+p].pop_front();
					delivered[srcOf[p]]++;
					if (front != outData[p]) begin
						errors++;
						$display("MISMATCH order: expected flit %h, actual flit %h",
							front, outData[p]);
					end
				end
			end else if (srcOf[p] >= 0) begin
				errors++;
				$display("ERROR: flit from input %0d never appeared on output %0d", srcOf[p], p);
				void'(pairQ[srcOf[p]*NP+p].pop_front());
			end
			// credit driven on the previous falling edge
			if (creditIn[p]) downCredits[p]++;
		end
	endtask

	task automatic driveInputs();
		logic [31:0] r;
		logic [3:0] x;
		logic [3:0] y;
		int dest;
		for (int i = 0; i < NP; i++) begin
			inValid[i] = 1'b0;
			r = nextRand();
			if (sent[i] < FLITS && upCredits[i] > 0 && r[1:0] != 2'b00) begin
				x = r[11:8];
				y = r[15:12];
				if (r[19:16] < 4'd5) y = 4'(HERE);
				if (r[23:20] < 4'd5) x = 4'(HERE);
				inData[i] = {x, y};
				inValid[i] = 1'b1;
				sent[i]++;
				upCredits[i]--;
				dest = yFirstOut({x, y});
				if (isDropped(i, dest)) begin
					routeQ[i].push_back(DROP);
					dropsExpected[i]++;
				end else begin
					routeQ[i].push_back(dest);
					pairQ[i*NP+dest].push_back({x, y});
				end
			end
		end
		for (int p = 0; p < NP; p++) begin
			creditIn[p] = 1'b0;
			// downstream credits held back during the stall window
			if ((cycle < STALL_START || cycle >= STALL_START + STALL_LEN)
				&& returnQ[p].size() > 0 && returnQ[p][0] <= cycle) begin
				void'(returnQ[p].pop_front());
				creditIn[p] = 1'b1;
			end
		end
	endtask

	task automatic finalChecks();
		for (int i = 0; i < NP; i++) begin
			if (creditPulses[i] != delivered[i] + dropsExpected[i]) begin
				errors++;
				$display("MISMATCH credits: input %0d expected %0d, actual %0d",
					i, delivered[i] + dropsExpected[i], creditPulses[i]);
			end
			for (int p = 0; p < NP; p++) begin
				if (pairQ[i*NP+p].size() != 0) begin
					errors++;
					$display("ERROR: %0d flits from input %0d to output %0d were never delivered",
						pairQ[i*NP+p].size(), i, p);
				end
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		reset_i = 1'b1;
		inData = '0;
		inValid = '0;
		creditIn = '0;
		rngState = 32'd30512;
		cycle = 0;
		errors = 0;
		idleCycles = 0;
		for (int i = 0; i < NP; i++) begin
			sent[i] = 0;
			upCredits[i] = nocPkg::BUF_DEPTH;
			downCredits[i] = nocPkg::BUF_DEPTH;
			creditPulses[i] = 0;
			delivered[i] = 0;
			dropsExpected[i] = 0;
		end
	end

	always @(negedge clk) begin
		cycle++;
		// reset edges plus the first cycle after
		if (cycle <= 9 && (outValid !== '0 || creditOut !== '0)) begin
			errors++;
			$display("MISMATCH reset: expected %b %b, actual %b %b",
				{NP{1'b0}}, {NP{1'b0}}, outValid, creditOut);
		end
		if (cycle == 8) reset_i = 1'b0;
		if (cycle >= TIMEOUT) begin
			errors++;
			$display("ERROR: timeout after %0d cycles, traffic did not drain", cycle);
			$display("errors: %0d", errors);
			$display("Regression failed");
			$finish;
		end else if (idleCycles >= 20) begin
			finalChecks();
			$display("errors: %0d", errors);
			if (errors == 0) begin
				$display("Regression passed");
			end else begin
				$display("Regression failed");
			end
			$finish;
		end else if (cycle > 8) begin
			checkOutputs();
			driveInputs();
			idleCycles++;
			for (int i = 0; i < NP; i++) begin
				if (sent[i] < FLITS || routeQ[i].size() != 0) idleCycles = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: compile.f
common/nocPkg.sv
common/outPortIf.sv
router/inputBuffer.sv
router/routeLogic.sv
router/outputStage.sv
design/meshRouter.sv
dv/routerProps.sv
dv/tbMeshRouter.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tbMeshRouter
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
